//--- src/simd_settings.svh
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// Number of 32-bit lanes in a vector register.
`define SIMD_LANES 16

`define SIMD_REGS 32

`define SIMD_RESET_PC 32'h0000_0000

`endif

//--- src/simd_pkg.sv
`include "simd_settings.svh"

package simd_pkg;

	typedef logic [31:0] word_t;

	typedef word_t [`SIMD_LANES-1:0] vector_t;	// Lane 0 sits in the low bits.

	typedef logic [4:0] reg_idx_t;

	typedef enum logic [5:0] {
		OP_NOP   = 6'd0,
		OP_SADD  = 6'd1,
		OP_SSUB  = 6'd2,
		OP_SAND  = 6'd3,
		OP_SADDI = 6'd4,
		OP_VADD  = 6'd5,
		OP_VADDS = 6'd6,
		OP_VEXT  = 6'd7,
		OP_LOAD  = 6'd8,
		OP_STORE = 6'd9,
		OP_BEQZ  = 6'd10
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		word_t pc;
		reg_idx_t dest;
		word_t immediate;		// Already sign extended.
		logic has_writeback;
		logic writeback_is_vector;
	} decoded_t;

endpackage

//--- src/writeback_if.sv
`timescale 1ns/1ns

interface writeback_if;

	logic has_writeback;		// The only valid flag on the bus.
	simd_pkg::reg_idx_t writeback_reg;
	logic is_vector;
	simd_pkg::vector_t value;	// Scalars travel in lane 0.
	simd_pkg::word_t pc;

	modport source (
		output has_writeback, writeback_reg, is_vector, value, pc
	);

	modport sink (
		input has_writeback, writeback_reg, is_vector, value, pc
	);

endinterface

//--- src/instruction_fetch_stage.sv
`timescale 1ns/1ns
`include "simd_settings.svh"

module instruction_fetch_stage (
	input  logic clk,
	input  logic arst_n_i,
	input  logic rollback_i,
	input  simd_pkg::word_t rollback_pc_i,
	output simd_pkg::word_t iaddress_o,
	output logic iaccess_o,
	input  simd_pkg::word_t idata_i,
	output simd_pkg::word_t instruction_o,
	output simd_pkg::word_t pc_o
);

	localparam simd_pkg::word_t nop_instruction = {simd_pkg::OP_NOP, 26'd0};

	simd_pkg::word_t pc_q;

	assign iaddress_o = pc_q;
	assign iaccess_o = 1'b1;	// The core fetches on every cycle.

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			pc_q <= `SIMD_RESET_PC;
			instruction_o <= nop_instruction;
		end
		else
		begin
			pc_q <= rollback_i ? rollback_pc_i : pc_q + 32'd4;
			instruction_o <= rollback_i ? nop_instruction : idata_i;	// Drop the wrong path.
		end
	end

	always_ff @(posedge clk)
	begin
		pc_o <= pc_q;
	end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic clk,
	input  logic arst_n_i,
	input  logic flush_i,
	input  simd_pkg::word_t instruction_i,
	input  simd_pkg::word_t pc_i,
	output simd_pkg::decoded_t decoded_o,
	output simd_pkg::reg_idx_t scalar_sel1_o,
	output simd_pkg::reg_idx_t scalar_sel2_o,
	output simd_pkg::reg_idx_t vector_sel1_o,
	output simd_pkg::reg_idx_t vector_sel2_o
);

	simd_pkg::opcode_e opcode;
	simd_pkg::reg_idx_t dest;
	simd_pkg::reg_idx_t src1;
	simd_pkg::reg_idx_t src2;
	simd_pkg::decoded_t decoded_d;

	assign opcode = simd_pkg::opcode_e'(instruction_i[31:26]);
	assign dest = instruction_i[25:21];
	assign src1 = instruction_i[20:16];
	assign src2 = instruction_i[15:11];

	// The register files read on the next edge, so the selects leave here unregistered.
	assign scalar_sel1_o = src1;
	assign scalar_sel2_o = (opcode == simd_pkg::OP_STORE) ? dest : src2;	// Store data.
	assign vector_sel1_o = src1;
	assign vector_sel2_o = src2;

	always_comb
	begin
		decoded_d = '0;
		decoded_d.opcode = opcode;
		decoded_d.pc = pc_i;
		decoded_d.dest = dest;
		decoded_d.immediate = {{16{instruction_i[15]}}, instruction_i[15:0]};
		case (opcode)
			simd_pkg::OP_SADD, simd_pkg::OP_SSUB, simd_pkg::OP_SAND, simd_pkg::OP_SADDI,
			simd_pkg::OP_VEXT, simd_pkg::OP_LOAD:
				decoded_d.has_writeback = 1'b1;
			simd_pkg::OP_VADD, simd_pkg::OP_VADDS:
			begin
				decoded_d.has_writeback = 1'b1;
				decoded_d.writeback_is_vector = 1'b1;
			end
			simd_pkg::OP_NOP, simd_pkg::OP_STORE, simd_pkg::OP_BEQZ:
				decoded_d.has_writeback = 1'b0;
			default:
				decoded_d.opcode = simd_pkg::OP_NOP;	// Unknown opcodes do nothing.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			decoded_o <= '0;
		else
			decoded_o <= flush_i ? '0 : decoded_d;	// An all-zero entry is a NOP.
	end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ns
`include "simd_settings.svh"

module register_file #(
	parameter type entry_t = simd_pkg::word_t
) (
	input  logic clk,
	input  simd_pkg::reg_idx_t sel1_i,
	input  simd_pkg::reg_idx_t sel2_i,
	output entry_t value1_o,
	output entry_t value2_o,
	writeback_if.sink wb
);

	localparam logic is_vector_entry = ($bits(entry_t) == $bits(simd_pkg::vector_t));

	entry_t regs [`SIMD_REGS];

	initial
	begin
		for (int i = 0; i < `SIMD_REGS; i++)
			regs[i] = '0;	// Registers start at zero.
	end

	always_ff @(posedge clk)
	begin
		if (wb.has_writeback && wb.is_vector == is_vector_entry)
			regs[wb.writeback_reg] <= entry_t'(wb.value);	// Scalars keep lane 0.
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ns
`include "simd_settings.svh"

module execute_stage (
	input  logic clk,
	input  logic arst_n_i,
	input  simd_pkg::decoded_t decoded_i,
	input  simd_pkg::word_t scalar_value1_i,
	input  simd_pkg::word_t scalar_value2_i,
	input  simd_pkg::vector_t vector_value1_i,
	input  simd_pkg::vector_t vector_value2_i,
	input  simd_pkg::reg_idx_t scalar_sel1_i,
	input  simd_pkg::reg_idx_t scalar_sel2_i,
	input  simd_pkg::reg_idx_t vector_sel1_i,
	input  simd_pkg::reg_idx_t vector_sel2_i,
	writeback_if.sink ma,
	writeback_if.sink wb,
	writeback_if.sink rf,
	writeback_if.source out,
	output simd_pkg::word_t daddress_o,
	output simd_pkg::word_t ddata_o,
	output logic daccess_o,
	output logic dwrite_o,
	output logic load_o,
	output logic rollback_o,
	output simd_pkg::word_t rollback_pc_o
);

	simd_pkg::reg_idx_t scalar_sel1_q;
	simd_pkg::reg_idx_t scalar_sel2_q;
	simd_pkg::reg_idx_t vector_sel1_q;
	simd_pkg::reg_idx_t vector_sel2_q;
	simd_pkg::vector_t op_s1;
	simd_pkg::vector_t op_s2;
	simd_pkg::vector_t op_v1;
	simd_pkg::vector_t op_v2;
	simd_pkg::word_t s1;
	simd_pkg::word_t s2;
	simd_pkg::word_t scalar_result;
	simd_pkg::vector_t lane_result;
	logic [$clog2(`SIMD_LANES)-1:0] lane;

	// Newest producer wins; the register file copy may be stale by up to three instructions.
	function automatic simd_pkg::vector_t forward(simd_pkg::reg_idx_t sel, logic vector_op,
			simd_pkg::vector_t file_value);
		if (ma.has_writeback && ma.is_vector == vector_op && ma.writeback_reg == sel)
			return ma.value;
		if (wb.has_writeback && wb.is_vector == vector_op && wb.writeback_reg == sel)
			return wb.value;
		if (rf.has_writeback && rf.is_vector == vector_op && rf.writeback_reg == sel)
			return rf.value;
		return file_value;
	endfunction

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scalar_sel1_q <= '0;
			scalar_sel2_q <= '0;
			vector_sel1_q <= '0;
			vector_sel2_q <= '0;
		end
		else
		begin
			scalar_sel1_q <= scalar_sel1_i;	// Match the register file read latency.
			scalar_sel2_q <= scalar_sel2_i;
			vector_sel1_q <= vector_sel1_i;
			vector_sel2_q <= vector_sel2_i;
		end
	end

	always_comb
	begin
		op_s1 = forward(scalar_sel1_q, 1'b0, simd_pkg::vector_t'(scalar_value1_i));
		op_s2 = forward(scalar_sel2_q, 1'b0, simd_pkg::vector_t'(scalar_value2_i));
		op_v1 = forward(vector_sel1_q, 1'b1, vector_value1_i);
		op_v2 = forward(vector_sel2_q, 1'b1, vector_value2_i);
	end

	assign s1 = op_s1[0];
	assign s2 = op_s2[0];
	assign lane = decoded_i.immediate[$clog2(`SIMD_LANES)-1:0];

	always_comb
	begin
		case (decoded_i.opcode)
			simd_pkg::OP_SADD:  scalar_result = s1 + s2;
			simd_pkg::OP_SSUB:  scalar_result = s1 - s2;
			simd_pkg::OP_SAND:  scalar_result = s1 & s2;
			simd_pkg::OP_SADDI: scalar_result = s1 + decoded_i.immediate;
			simd_pkg::OP_VEXT:  scalar_result = op_v1[lane];
			default:            scalar_result = '0;
		endcase
	end

	always_comb
	begin
		for (int i = 0; i < `SIMD_LANES; i++)
			lane_result[i] = op_v1[i] + ((decoded_i.opcode == simd_pkg::OP_VADDS) ? s2 : op_v2[i]);
	end

	assign out.has_writeback = decoded_i.has_writeback;
	assign out.writeback_reg = decoded_i.dest;
	assign out.is_vector = decoded_i.writeback_is_vector;
	assign out.value = decoded_i.writeback_is_vector ? lane_result
		: simd_pkg::vector_t'(scalar_result);
	assign out.pc = decoded_i.pc;

	assign daddress_o = s1 + decoded_i.immediate;
	assign ddata_o = s2;
	assign load_o = (decoded_i.opcode == simd_pkg::OP_LOAD);
	assign dwrite_o = (decoded_i.opcode == simd_pkg::OP_STORE);
	assign daccess_o = load_o || dwrite_o;

	// Fetch and decode flush on this same edge, so the branch shadow never reaches here.
	assign rollback_o = (decoded_i.opcode == simd_pkg::OP_BEQZ) && (s1 == '0);
	assign rollback_pc_o = decoded_i.pc + decoded_i.immediate;

endmodule

//--- src/memory_access_stage.sv
`timescale 1ns/1ns

module memory_access_stage (
	input  logic clk,
	input  logic arst_n_i,
	writeback_if.sink in,
	input  simd_pkg::word_t daddress_i,
	input  simd_pkg::word_t ddata_i,
	input  logic daccess_i,
	input  logic dwrite_i,
	input  logic load_i,
	output simd_pkg::word_t daddress_o,
	output simd_pkg::word_t ddata_o,
	output logic daccess_o,
	output logic dwrite_o,
	writeback_if.source out,
	output logic load_o
);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			out.has_writeback <= 1'b0;
			daccess_o <= 1'b0;
			dwrite_o <= 1'b0;
			load_o <= 1'b0;
		end
		else
		begin
			out.has_writeback <= in.has_writeback;
			daccess_o <= daccess_i;
			dwrite_o <= dwrite_i;
			load_o <= load_i;	// Load data comes back while this sits in writeback.
		end
	end

	always_ff @(posedge clk)
	begin
		out.writeback_reg <= in.writeback_reg;
		out.is_vector <= in.is_vector;
		out.value <= in.value;
		out.pc <= in.pc;
		daddress_o <= daddress_i;
		ddata_o <= ddata_i;
	end

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
	input  logic clk,
	input  logic arst_n_i,
	writeback_if.sink in,
	input  logic load_i,
	input  simd_pkg::word_t ddata_i,
	writeback_if.source wb,
	writeback_if.source rf
);

	logic has_writeback_q;
	logic load_q;
	simd_pkg::reg_idx_t writeback_reg_q;
	logic is_vector_q;
	simd_pkg::vector_t value_q;
	simd_pkg::word_t pc_q;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			has_writeback_q <= 1'b0;
			load_q <= 1'b0;
			rf.has_writeback <= 1'b0;
		end
		else
		begin
			has_writeback_q <= in.has_writeback;
			load_q <= load_i;
			rf.has_writeback <= wb.has_writeback;
		end
	end

	always_ff @(posedge clk)
	begin
		writeback_reg_q <= in.writeback_reg;
		is_vector_q <= in.is_vector;
		value_q <= in.value;
		pc_q <= in.pc;
		rf.writeback_reg <= wb.writeback_reg;	// The register files still read stale data here.
		rf.is_vector <= wb.is_vector;
		rf.value <= wb.value;
		rf.pc <= wb.pc;
	end

	assign wb.has_writeback = has_writeback_q;
	assign wb.writeback_reg = writeback_reg_q;
	assign wb.is_vector = is_vector_q;
	assign wb.value = load_q ? simd_pkg::vector_t'(ddata_i) : value_q;	// Loaded word in lane 0.
	assign wb.pc = pc_q;

endmodule

//--- src/simd_core.sv
`timescale 1ns/1ns

module simd_core (
	input  logic clk,
	input  logic arst_n_i,
	output logic [31:0] iaddress_o,
	input  logic [31:0] idata_i,
	output logic iaccess_o,
	output logic [31:0] daddress_o,
	output logic daccess_o,
	output logic dwrite_o,
	output logic [31:0] ddata_o,
	input  logic [31:0] ddata_i
);

	simd_pkg::word_t if_instruction;
	simd_pkg::word_t if_pc;
	simd_pkg::decoded_t ds_decoded;
	simd_pkg::reg_idx_t scalar_sel1;
	simd_pkg::reg_idx_t scalar_sel2;
	simd_pkg::reg_idx_t vector_sel1;
	simd_pkg::reg_idx_t vector_sel2;
	simd_pkg::word_t scalar_value1;
	simd_pkg::word_t scalar_value2;
	simd_pkg::vector_t vector_value1;
	simd_pkg::vector_t vector_value2;
	simd_pkg::word_t ex_daddress;
	simd_pkg::word_t ex_ddata;
	logic ex_daccess;
	logic ex_dwrite;
	logic ex_load;
	logic ma_load;
	logic rollback;
	simd_pkg::word_t rollback_pc;

	writeback_if ex_bus ();
	writeback_if ma_bus ();
	writeback_if wb_bus ();
	writeback_if rf_bus ();	// Writeback bus one cycle late.

	instruction_fetch_stage ifs (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rollback_i(rollback),
		.rollback_pc_i(rollback_pc),
		.iaddress_o(iaddress_o),
		.iaccess_o(iaccess_o),
		.idata_i(idata_i),
		.instruction_o(if_instruction),
		.pc_o(if_pc)
	);

	decode_stage ds (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.flush_i(rollback),
		.instruction_i(if_instruction),
		.pc_i(if_pc),
		.decoded_o(ds_decoded),
		.scalar_sel1_o(scalar_sel1),
		.scalar_sel2_o(scalar_sel2),
		.vector_sel1_o(vector_sel1),
		.vector_sel2_o(vector_sel2)
	);

	register_file #(.entry_t(simd_pkg::word_t)) srf (
		.clk(clk),
		.sel1_i(scalar_sel1),
		.sel2_i(scalar_sel2),
		.value1_o(scalar_value1),
		.value2_o(scalar_value2),
		.wb(wb_bus.sink)
	);

	register_file #(.entry_t(simd_pkg::vector_t)) vrf (
		.clk(clk),
		.sel1_i(vector_sel1),
		.sel2_i(vector_sel2),
		.value1_o(vector_value1),
		.value2_o(vector_value2),
		.wb(wb_bus.sink)
	);

	execute_stage exs (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.decoded_i(ds_decoded),
		.scalar_value1_i(scalar_value1),
		.scalar_value2_i(scalar_value2),
		.vector_value1_i(vector_value1),
		.vector_value2_i(vector_value2),
		.scalar_sel1_i(scalar_sel1),
		.scalar_sel2_i(scalar_sel2),
		.vector_sel1_i(vector_sel1),
		.vector_sel2_i(vector_sel2),
		.ma(ma_bus.sink),
		.wb(wb_bus.sink),
		.rf(rf_bus.sink),
		.out(ex_bus.source),
		.daddress_o(ex_daddress),
		.ddata_o(ex_ddata),
		.daccess_o(ex_daccess),
		.dwrite_o(ex_dwrite),
		.load_o(ex_load),
		.rollback_o(rollback),
		.rollback_pc_o(rollback_pc)
	);

	memory_access_stage mas (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.in(ex_bus.sink),
		.daddress_i(ex_daddress),
		.ddata_i(ex_ddata),
		.daccess_i(ex_daccess),
		.dwrite_i(ex_dwrite),
		.load_i(ex_load),
		.daddress_o(daddress_o),
		.ddata_o(ddata_o),
		.daccess_o(daccess_o),
		.dwrite_o(dwrite_o),
		.out(ma_bus.source),
		.load_o(ma_load)
	);

	writeback_stage wbs (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.in(ma_bus.sink),
		.load_i(ma_load),
		.ddata_i(ddata_i),
		.wb(wb_bus.source),
		.rf(rf_bus.source)
	);

endmodule

//--- testbench/simd_core_sva.sv
`timescale 1ns/1ns
`include "simd_settings.svh"

module simd_core_sva (
	input logic clk,
	input logic arst_n_i,
	input logic [31:0] iaddress_i,
	input logic iaccess_i,
	input logic daccess_i,
	input logic dwrite_i,
	input logic rollback_i,
	input logic [31:0] branch_pc_i,
	input logic [31:0] branch_offset_i
);

	int unsigned failure_count = 0;

	first_fetch: assert property (@(posedge clk) $rose(arst_n_i) |-> iaddress_i == `SIMD_RESET_PC)
	else
	begin
		failure_count++;
		$error("First fetch after reset is not at the reset PC.");
	end

	// Straight-line fetch unless a branch redirected the previous cycle.
	fetch_sequence: assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(arst_n_i) && !$past(rollback_i) |-> iaddress_i == $past(iaddress_i) + 32'd4)
	else
	begin
		failure_count++;
		$error("Fetch address did not advance by 4.");
	end

	branch_target: assert property (@(posedge clk) disable iff (!arst_n_i)
		rollback_i |=> iaddress_i == $past(branch_pc_i + branch_offset_i))
	else
	begin
		failure_count++;
		$error("Fetch did not restart at the branch target.");
	end

	fetch_enabled: assert property (@(posedge clk) disable iff (!arst_n_i) iaccess_i)
	else
	begin
		failure_count++;
		$error("Instruction fetch strobe dropped.");
	end

	write_with_access: assert property (@(posedge clk) dwrite_i |-> daccess_i)
	else
	begin
		failure_count++;
		$error("Data write strobe without data access.");
	end

	quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !daccess_i)
	else
	begin
		failure_count++;
		$error("Data access during reset.");
	end

endmodule

bind simd_core simd_core_sva core_checks (
	.clk(clk),
	.arst_n_i(arst_n_i),
	.iaddress_i(iaddress_o),
	.iaccess_i(iaccess_o),
	.daccess_i(daccess_o),
	.dwrite_i(dwrite_o),
	.rollback_i(rollback),
	.branch_pc_i(ds_decoded.pc),
	.branch_offset_i(ds_decoded.immediate)
);

//--- testbench/simd_core_tb.sv
`timescale 1ns/1ns
`include "simd_settings.svh"

module simd_core_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int PROGRAM_LENGTH = 38;
	localparam int MEM_WORDS = 64;
	localparam logic [31:0] HALT_PC = 32'd148;	// Word 37 branches to itself.
	localparam logic [31:0] LFSR_SEED = 32'h80a1_53a3;

	logic clk;
	logic arst_n_i;
	logic [31:0] iaddress_o;
	logic [31:0] idata_i;
	logic iaccess_o;
	logic [31:0] daddress_o;
	logic daccess_o;
	logic dwrite_o;
	logic [31:0] ddata_o;
	logic [31:0] ddata_i;

	logic [31:0] data_mem [MEM_WORDS];
	logic [31:0] read_data;
	logic [31:0] last_fetch;
	logic halt_reached;
	logic [31:0] expected_address [$];
	logic [31:0] expected_data [$];
	int value_errors;
	int other_errors;

	simd_core simd_core_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.iaddress_o(iaddress_o),
		.idata_i(idata_i),
		.iaccess_o(iaccess_o),
		.daddress_o(daddress_o),
		.daccess_o(daccess_o),
		.dwrite_o(dwrite_o),
		.ddata_o(ddata_o),
		.ddata_i(ddata_i)
	);

	function automatic logic [31:0] encode_r(input logic [5:0] op, input logic [4:0] d,
			input logic [4:0] s1, input logic [4:0] s2);
		return {op, d, s1, s2, 11'd0};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] d,
			input logic [4:0] s1, input logic [15:0] imm);
		return {op, d, s1, imm};
	endfunction

	function automatic logic [31:0] program_word(input logic [31:0] address);
		case (address[9:2])
			8'd0:  return encode_i(simd_pkg::OP_SADDI, 5'd1, 5'd0, 16'h0135);
			8'd1:  return encode_i(simd_pkg::OP_SADDI, 5'd2, 5'd1, 16'h00f0);	// Distance 1.
			8'd2:  return encode_r(simd_pkg::OP_SADD, 5'd3, 5'd2, 5'd1);
			8'd3:  return encode_r(simd_pkg::OP_SSUB, 5'd4, 5'd3, 5'd1);	// r1 at distance 3.
			8'd4:  return encode_r(simd_pkg::OP_SAND, 5'd5, 5'd4, 5'd2);
			8'd5:  return encode_i(simd_pkg::OP_STORE, 5'd5, 5'd0, 16'h0000);
			8'd6:  return encode_i(simd_pkg::OP_STORE, 5'd4, 5'd0, 16'h0004);
			8'd7:  return encode_i(simd_pkg::OP_STORE, 5'd3, 5'd0, 16'h0008);
			8'd8:  return encode_i(simd_pkg::OP_SADDI, 5'd6, 5'd0, 16'h0040);
			8'd9:  return encode_i(simd_pkg::OP_STORE, 5'd2, 5'd6, 16'h0004);	// Address bypassed.
			8'd10: return encode_r(simd_pkg::OP_VADDS, 5'd1, 5'd0, 5'd1);
			8'd11: return encode_r(simd_pkg::OP_VADDS, 5'd2, 5'd1, 5'd2);
			8'd12: return encode_r(simd_pkg::OP_VADD, 5'd3, 5'd2, 5'd1);
			8'd13: return encode_i(simd_pkg::OP_VEXT, 5'd7, 5'd3, 16'd0);
			8'd14: return encode_i(simd_pkg::OP_VEXT, 5'd8, 5'd3, 16'd5);
			8'd15: return encode_i(simd_pkg::OP_VEXT, 5'd9, 5'd2, 16'd15);
			8'd16: return encode_i(simd_pkg::OP_STORE, 5'd7, 5'd0, 16'h000c);
			8'd17: return encode_i(simd_pkg::OP_STORE, 5'd8, 5'd0, 16'h0010);
			8'd18: return encode_i(simd_pkg::OP_STORE, 5'd9, 5'd0, 16'h0014);
			8'd19: return encode_i(simd_pkg::OP_LOAD, 5'd10, 5'd0, 16'h0020);
			8'd20: return '0;
			8'd21: return encode_i(simd_pkg::OP_SADDI, 5'd11, 5'd10, 16'h0011);	// Load use.
			8'd22: return encode_i(simd_pkg::OP_STORE, 5'd11, 5'd0, 16'h0018);
			8'd23: return encode_i(simd_pkg::OP_LOAD, 5'd12, 5'd6, 16'h0004);
			8'd24: return encode_i(simd_pkg::OP_SADDI, 5'd13, 5'd0, 16'h0003);
			8'd25: return encode_r(simd_pkg::OP_SADD, 5'd14, 5'd12, 5'd13);
			8'd26: return encode_i(simd_pkg::OP_STORE, 5'd14, 5'd0, 16'h001c);
			8'd27: return encode_i(simd_pkg::OP_BEQZ, 5'd0, 5'd1, 16'd16);	// Not taken.
			8'd28: return encode_i(simd_pkg::OP_STORE, 5'd1, 5'd0, 16'h0028);
			8'd29: return encode_i(simd_pkg::OP_BEQZ, 5'd0, 5'd0, 16'd16);
			8'd30: return encode_i(simd_pkg::OP_STORE, 5'd2, 5'd0, 16'h002c);	// Shadow.
			8'd31: return encode_i(simd_pkg::OP_STORE, 5'd3, 5'd0, 16'h0030);	// Shadow.
			8'd32: return encode_i(simd_pkg::OP_STORE, 5'd4, 5'd0, 16'h0034);
			8'd33: return encode_r(simd_pkg::OP_SSUB, 5'd15, 5'd1, 5'd1);
			8'd34: return encode_i(simd_pkg::OP_BEQZ, 5'd0, 5'd15, 16'd8);
			8'd35: return encode_i(simd_pkg::OP_STORE, 5'd1, 5'd0, 16'h0038);
			8'd36: return encode_i(simd_pkg::OP_STORE, 5'd2, 5'd0, 16'h003c);
			8'd37: return encode_i(simd_pkg::OP_BEQZ, 5'd0, 5'd0, 16'd0);
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic fill_memory();
		logic [31:0] state;
		logic [31:0] word;
		state = LFSR_SEED;
		for (int w = 0; w < MEM_WORDS; w++)
		begin
			for (int b = 0; b < 32; b++)
			begin
				state = lfsr_next(state);
				word = {word[30:0], state[0]};	// One step per bit.
			end
			data_mem[w] = word;
		end
	endtask

	// Instruction-set model of the program; it yields the stores in program order.
	task automatic run_golden_model();
		logic [31:0] sregs [`SIMD_REGS];
		logic [31:0] vregs [`SIMD_REGS][`SIMD_LANES];
		logic [31:0] gmem [MEM_WORDS];
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] instr;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [5:0] op;
		logic [4:0] d;
		logic [4:0] s1;
		logic [4:0] s2;
		int steps;
		for (int r = 0; r < `SIMD_REGS; r++)
		begin
			sregs[r] = '0;
			for (int l = 0; l < `SIMD_LANES; l++)
				vregs[r][l] = '0;
		end
		gmem = data_mem;
		pc = `SIMD_RESET_PC;
		steps = 0;
		while (pc != HALT_PC && steps < PROGRAM_LENGTH * 2)
		begin
			instr = program_word(pc);
			op = instr[31:26];
			d = instr[25:21];
			s1 = instr[20:16];
			s2 = instr[15:11];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = sregs[s1] + imm;
			next_pc = pc + 32'd4;
			case (op)
				simd_pkg::OP_SADD:  sregs[d] = sregs[s1] + sregs[s2];
				simd_pkg::OP_SSUB:  sregs[d] = sregs[s1] - sregs[s2];
				simd_pkg::OP_SAND:  sregs[d] = sregs[s1] & sregs[s2];
				simd_pkg::OP_SADDI: sregs[d] = sregs[s1] + imm;
				simd_pkg::OP_VADD:
					for (int l = 0; l < `SIMD_LANES; l++)
						vregs[d][l] = vregs[s1][l] + vregs[s2][l];
				simd_pkg::OP_VADDS:
					for (int l = 0; l < `SIMD_LANES; l++)
						vregs[d][l] = vregs[s1][l] + sregs[s2];
				simd_pkg::OP_VEXT:  sregs[d] = vregs[s1][imm % `SIMD_LANES];
				simd_pkg::OP_LOAD:  sregs[d] = gmem[addr[7:2]];
				simd_pkg::OP_STORE:
				begin
					gmem[addr[7:2]] = sregs[d];
					expected_address.push_back(addr);
					expected_data.push_back(sregs[d]);
				end
				simd_pkg::OP_BEQZ:
					if (sregs[s1] == '0)
						next_pc = pc + imm;
				default: ;
			endcase
			pc = next_pc;
			steps++;
		end
	endtask

	task automatic check_store(input logic [31:0] address, input logic [31:0] data);
		logic [31:0] want_address;
		logic [31:0] want_data;
		if (expected_address.size() == 0)
		begin
			other_errors++;
			$display("Unexpected store of %h to address %h at %0t ns.", data, address, $time);
		end
		else
		begin
			want_address = expected_address.pop_front();
			want_data = expected_data.pop_front();
			assert (address == want_address && data == want_data)
			else
			begin
				value_errors++;
				$display("Error at %0t ns: store wrote %h to %h, expected %h to %h.",
					$time, data, address, want_data, want_address);
			end
		end
		data_mem[address[7:2]] = data;
	endtask

	task automatic print_counts();
		$display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
			value_errors, other_errors, simd_core_i.core_checks.failure_count);
	endtask

	always #(CLK_PERIOD / 2) clk = ~clk;

	assign idata_i = program_word(iaddress_o);	// Instruction ROM answers at once.

	// Data memory and store monitor, both working 1 ns after the edge.
	always @(posedge clk)
	begin
		#1;
		ddata_i = read_data;
		if (iaddress_o == HALT_PC && last_fetch == HALT_PC + 32'd8)
			halt_reached = 1'b1;
		last_fetch = iaddress_o;
		if (daccess_o && !dwrite_o)
			read_data = data_mem[daddress_o[7:2]];
		if (daccess_o && dwrite_o)
			check_store(daddress_o, ddata_o);
	end

	initial
	begin
		clk = 1'b0;
		arst_n_i = 1'b1;
		ddata_i = '0;
		read_data = '0;
		last_fetch = '0;
		halt_reached = 1'b0;
		value_errors = 0;
		other_errors = 0;
		fill_memory();
		run_golden_model();
		#1 arst_n_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n_i = 1'b1;
		wait (halt_reached);
		if (expected_address.size() != 0)
		begin
			other_errors++;
			$display("Missing stores: %0d expected stores never reached the data port.",
				expected_address.size());
		end
		print_counts();
		if (value_errors == 0 && other_errors == 0 && simd_core_i.core_checks.failure_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		#((RESET_CYCLES + PROGRAM_LENGTH * 20) * CLK_PERIOD);
		$display("Timeout: the core never reached the halt loop at %h.", HALT_PC);
		print_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/simd_pkg.sv
src/writeback_if.sv
src/instruction_fetch_stage.sv
src/decode_stage.sv
src/register_file.sv
src/execute_stage.sv
src/memory_access_stage.sv
src/writeback_stage.sv
src/simd_core.sv
testbench/simd_core_sva.sv
testbench/simd_core_tb.sv

//--- Bender.yml
package:
  name: simd_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/simd_pkg.sv
      - src/writeback_if.sv
      - src/instruction_fetch_stage.sv
      - src/decode_stage.sv
      - src/register_file.sv
      - src/execute_stage.sv
      - src/memory_access_stage.sv
      - src/writeback_stage.sv
      - src/simd_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/simd_core_sva.sv
      - testbench/simd_core_tb.sv
